/* design/task_dispatch.sv */
//##########################################################
// moves the heap head into a one-entry slot per task type
// and serves each slot on its own valid/ready read port
//##########################################################

`timescale 1ns/1ps

`include "task_unit_config.svh"

module task_dispatch
   import task_pkg::*;
(
   input  logic                         clk,
   input  logic                         rst,

   // heap head
   input  tq_elem_s                     head,
   input  logic                         head_valid,
   output logic                         pop,

   // read ports, one per task type
   output logic  [0:`N_TASK_TYPES-1]    m_rvalid,
   input  logic  [0:`N_TASK_TYPES-1]    m_rready,
   output task_t [0:`N_TASK_TYPES-1]    m_rdata
);

   // slot picked by the head's type
   ttype_t sel;
   logic   slot_free;

   assign sel = head.ttype;

   // empty, or handing its task out this same edge
   assign slot_free = !m_rvalid[sel] || m_rready[sel];

   // a busy slot stalls the head and every type behind it
   assign pop = head_valid && slot_free;

   // slot occupancy
   always_ff @(posedge clk) begin
      if (rst) begin
         m_rvalid <= '0;
      end else begin
         for (int t = 0; t < `N_TASK_TYPES; t++) begin
            if (pop && (sel == ttype_t'(t))) begin
               m_rvalid[t] <= 1'b1;
            end else if (m_rready[t]) begin
               m_rvalid[t] <= 1'b0;
            end
         end
      end
   end

   // slot payload, only loaded on pop so it holds during a stall
   always_ff @(posedge clk) begin
      for (int t = 0; t < `N_TASK_TYPES; t++) begin
         if (pop && (sel == ttype_t'(t))) begin
            m_rdata[t] <= '{ts: head.ts, locale: head.locale};
         end
      end
   end

   // stalled read port keeps its task
   for (genvar t = 0; t < `N_TASK_TYPES; t++) begin : g_stable
      a_rdata_stable: assert property (
         @(posedge clk) disable iff (rst)
         m_rvalid[t] && !m_rready[t] |=> $stable(m_rdata[t])
      );
   end

endmodule

/* design/task_heap.sv */
//##########################################################
// binary min-heap of tasks keyed on timestamp, one insert or
// one extract at a time, one heap level per clock
//##########################################################

`timescale 1ns/1ps

`include "task_unit_config.svh"

module task_heap
   import task_pkg::*;
   import tq_pkg::*;
(
   input  logic     clk,
   input  logic     rst,

   // write side
   input  logic     s_wvalid,
   output logic     s_wready,
   input  tq_elem_s s_wdata,

   // head toward the dispatcher
   input  logic     pop,
   output tq_elem_s head,
   output logic     head_valid
);

   localparam heap_occ_t HEAP_SIZE = heap_occ_t'((1 << `TQ_STAGES) - 1);

   // element storage, minimum always at index 0
   tq_elem_s heap [0:HEAP_SIZE-1];

   heap_state_e state;
   heap_occ_t   occ;
   // element currently being sifted
   heap_idx_t   cur;

   logic      push;
   heap_idx_t wr_idx;
   heap_idx_t last_idx;

   // sift-up terms
   heap_idx_t parent;
   logic      up_swap;

   // sift-down terms
   heap_occ_t lchild;
   heap_occ_t rchild;
   heap_idx_t lidx;
   heap_idx_t ridx;
   logic      has_l;
   logic      has_r;
   heap_idx_t min_c;
   logic      min_c_inner;
   logic      down_swap;

   // head only counts once the heap has settled
   assign head       = heap[0];
   assign head_valid = (state == IDLE) && (occ != '0);

   // pop takes the cycle, a write must wait
   assign s_wready = (state == IDLE) && (occ != HEAP_SIZE) && !pop;
   assign push     = s_wvalid && s_wready;

   // new element lands after the last one
   assign wr_idx   = heap_idx_t'(occ);
   // last element refills the root on extract
   assign last_idx = heap_idx_t'(occ - 1'b1);

   always_comb begin
      // parent of cur, cur is never 0 in SIFT_UP
      parent  = (cur - 1'b1) >> 1;
      up_swap = (state == SIFT_UP) && (heap[cur].ts < heap[parent].ts);

      // children are 2*cur+1 and 2*cur+2
      lchild = {cur, 1'b1};
      rchild = lchild + 1'b1;
      lidx   = heap_idx_t'(lchild);
      ridx   = heap_idx_t'(rchild);
      // occ is already the post-pop count here
      has_l  = lchild < occ;
      has_r  = rchild < occ;

      // smaller child, left one on a tie
      if (has_r && (heap[ridx].ts < heap[lidx].ts)) begin
         min_c = ridx;
      end else begin
         min_c = lidx;
      end

      // swap target still has a child of its own
      min_c_inner = {min_c, 1'b1} < occ;
      down_swap   = (state == SIFT_DOWN) && has_l && (heap[min_c].ts < heap[cur].ts);
   end

   // control FSM
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
         occ   <= '0;
         cur   <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (pop) begin
                  occ   <= occ - 1'b1;
                  cur   <= '0;
                  state <= SIFT_DOWN;
               end else if (push) begin
                  occ <= occ + 1'b1;
                  cur <= wr_idx;
                  // first element is already the root
                  if (occ != '0) begin
                     state <= SIFT_UP;
                  end
               end
            end
            SIFT_UP: begin
               if (up_swap) begin
                  cur <= parent;
                  // reached the root, nothing left to compare
                  if (parent == '0) begin
                     state <= IDLE;
                  end
               end else begin
                  state <= IDLE;
               end
            end
            SIFT_DOWN: begin
               if (down_swap) begin
                  cur <= min_c;
                  // landed on a leaf, stop without another compare
                  if (!min_c_inner) begin
                     state <= IDLE;
                  end
               end else begin
                  state <= IDLE;
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // element moves, driven by the same FSM decisions
   always_ff @(posedge clk) begin
      case (state)
         IDLE: begin
            if (pop) begin
               heap[0] <= heap[last_idx];
            end else if (push) begin
               heap[wr_idx] <= s_wdata;
            end
         end
         SIFT_UP: begin
            if (up_swap) begin
               heap[parent] <= heap[cur];
               heap[cur]    <= heap[parent];
            end
         end
         SIFT_DOWN: begin
            if (down_swap) begin
               heap[min_c] <= heap[cur];
               heap[cur]   <= heap[min_c];
            end
         end
         default: begin
         end
      endcase
   end

   // dispatcher only pops a settled, non-empty heap
   a_pop_needs_head: assert property (
      @(posedge clk) disable iff (rst) pop |-> head_valid
   );

   // full heap blocks writes, so the count stays in range
   a_occ_range: assert property (
      @(posedge clk) disable iff (rst) occ <= HEAP_SIZE
   );

endmodule

/* design/task_pkg.sv */
//##########################################################
// types of a task as it enters and leaves the task unit;
// imported by the heap, the dispatcher and the top level
//##########################################################

`include "task_unit_config.svh"

package task_pkg;

   // field types
   typedef logic [`TS_W-1:0]     ts_t;
   typedef logic [`LOCALE_W-1:0] locale_t;
   typedef logic [`TTYPE_W-1:0]  ttype_t;

   // task as handed out on a read port
   // type is implied by the port it leaves on
   typedef struct packed {
      ts_t     ts;
      locale_t locale;
   } task_t;

   // task as written and as held in the heap
   typedef struct packed {
      ttype_t  ttype;
      locale_t locale;
      ts_t     ts;
   } tq_elem_s;

endpackage

/* design/task_unit.sv */
//##########################################################
// task unit top level: one write port into a timestamp heap,
// one read port per task type out of the dispatcher
//##########################################################

`timescale 1ns/1ps

`include "task_unit_config.svh"

module task_unit
   import task_pkg::*;
(
   input  logic                         clk,
   input  logic                         rst,

   // write port
   input  logic                         s_wvalid,
   output logic                         s_wready,
   input  tq_elem_s                     s_wdata,

   // read ports
   output logic  [0:`N_TASK_TYPES-1]    m_rvalid,
   input  logic  [0:`N_TASK_TYPES-1]    m_rready,
   output task_t [0:`N_TASK_TYPES-1]    m_rdata
);

   // heap to dispatcher
   tq_elem_s head;
   logic     head_valid;
   logic     pop;

   // ordered storage
   task_heap heap_i (
      .clk        (clk),
      .rst        (rst),
      .s_wvalid   (s_wvalid),
      .s_wready   (s_wready),
      .s_wdata    (s_wdata),
      .pop        (pop),
      .head       (head),
      .head_valid (head_valid)
   );

   // per-type output slots
   task_dispatch dispatch_i (
      .clk        (clk),
      .rst        (rst),
      .head       (head),
      .head_valid (head_valid),
      .pop        (pop),
      .m_rvalid   (m_rvalid),
      .m_rready   (m_rready),
      .m_rdata    (m_rdata)
   );

endmodule

/* design/task_unit_config.svh */
//##########################################################
// build-time sizing of the task unit: heap depth, task types
// and field widths; include before the packages and modules
//##########################################################

`ifndef TASK_UNIT_CONFIG_SVH
`define TASK_UNIT_CONFIG_SVH

// heap levels, heap holds (1 << TQ_STAGES) - 1 tasks
`define TQ_STAGES 4

// one read port and one output slot per task type
`define N_TASK_TYPES 4

// timestamp width, the only key the heap sorts on
`define TS_W 8

// locale carried along untouched
`define LOCALE_W 16

// must cover N_TASK_TYPES
`define TTYPE_W 2

`endif

/* design/tq_pkg.sv */
//##########################################################
// queue internals of the task heap: slot index, occupancy
// count and the heap FSM states
//##########################################################

`include "task_unit_config.svh"

package tq_pkg;

   // index of one heap slot, 0 is the root
   typedef logic [`TQ_STAGES-1:0] heap_idx_t;

   // number of tasks held, one bit wider than the index
   // so a full heap and child indices past the end both fit
   typedef logic [`TQ_STAGES:0] heap_occ_t;

   // IDLE: head valid, one insert or extract may start
   // SIFT_UP: new element climbs toward the root
   // SIFT_DOWN: moved element sinks toward the leaves
   typedef enum logic [1:0] {
      IDLE,
      SIFT_UP,
      SIFT_DOWN
   } heap_state_e;

endpackage

/* dv/tb_ref_queue.svh */
//############################################################
// testbench reference model of the task unit: tasks waiting
// in the heap, the task expected in each slot, and the LCG
//############################################################

`ifndef TB_REF_QUEUE_SVH
`define TB_REF_QUEUE_SVH

// tasks the model still holds in the heap
tq_elem_s    held_q[$];
// task expected in each per-type output slot
tq_elem_s    slot_elem [`N_TASK_TYPES];
logic        slot_full [`N_TASK_TYPES];
logic [31:0] lcg_state;

// 32-bit linear congruential generator
function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

function automatic void model_clear();
   held_q.delete();
   for (int t = 0; t < `N_TASK_TYPES; t++) begin
      slot_full[t] = 1'b0;
   end
endfunction

// smallest timestamp of type t, or of any type when t is negative
function automatic int min_index(input int t);
   int best;
   best = -1;
   for (int i = 0; i < held_q.size(); i++) begin
      if ((t < 0 || held_q[i].ttype == ttype_t'(t)) &&
          (best < 0 || held_q[i].ts < held_q[best].ts)) begin
         best = i;
      end
   end
   return best;
endfunction

// the heap head moves into its slot while that slot is empty
// a full slot for the head blocks every other type
function automatic void model_settle();
   int   i;
   logic more;
   more = 1'b1;
   while (more) begin
      i = min_index(-1);
      if (i < 0 || slot_full[held_q[i].ttype]) begin
         more = 1'b0;
      end else begin
         slot_elem[held_q[i].ttype] = held_q[i];
         slot_full[held_q[i].ttype] = 1'b1;
         held_q.delete(i);
      end
   end
endfunction

function automatic void model_write(input tq_elem_s e);
   held_q.push_back(e);
   model_settle();
endfunction

// next task on port t
// the slot goes first, then that type's heap tasks by timestamp
function automatic logic model_expect(input int t, output tq_elem_s e);
   int i;
   e = '0;
   if (slot_full[t]) begin
      e = slot_elem[t];
      slot_full[t] = 1'b0;
      return 1'b1;
   end
   i = min_index(t);
   if (i < 0) begin
      return 1'b0;
   end
   e = held_q[i];
   held_q.delete(i);
   return 1'b1;
endfunction

function automatic int model_count();
   int n;
   n = held_q.size();
   for (int t = 0; t < `N_TASK_TYPES; t++) begin
      if (slot_full[t]) begin
         n++;
      end
   end
   return n;
endfunction

// timestamps are kept unique so the expected order is fixed
function automatic logic ts_in_use(input ts_t ts);
   foreach (held_q[i]) begin
      if (held_q[i].ts == ts) begin
         return 1'b1;
      end
   end
   for (int t = 0; t < `N_TASK_TYPES; t++) begin
      if (slot_full[t] && slot_elem[t].ts == ts) begin
         return 1'b1;
      end
   end
   return 1'b0;
endfunction

`endif

/* dv/tb_task_unit.sv */
//############################################################
// directed testbench of the task unit: ordering, routing,
// back-pressure, read stalls and reset against a model
//############################################################

`timescale 1ns/1ps

`include "task_unit_config.svh"

module tb_task_unit
   import task_pkg::*;
();

   localparam int N        = `N_TASK_TYPES;
   localparam int WAIT_MAX = 300;

   logic           clk;
   logic           rst;
   logic           s_wvalid;
   logic           s_wready;
   tq_elem_s       s_wdata;
   logic  [0:N-1]  m_rvalid;
   logic  [0:N-1]  m_rready;
   task_t [0:N-1]  m_rdata;

   int          errors;
   // unique locale per task, so each read names its write
   logic [15:0] locale_seq;

   `include "tb_ref_queue.svh"

   task_unit dut_i (
      .clk      (clk),
      .rst      (rst),
      .s_wvalid (s_wvalid),
      .s_wready (s_wready),
      .s_wdata  (s_wdata),
      .m_rvalid (m_rvalid),
      .m_rready (m_rready),
      .m_rdata  (m_rdata)
   );

   // 4 ns clock
   always #2 clk = ~clk;

   task automatic check(input string test, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("mismatch in %s: expected %0h, actual %0h", test, expected, actual);
         $display("TEST FAIL");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic stop_run(input string what);
      errors++;
      $display("%s", what);
      $display("TEST FAIL");
      $fatal(1, "run stopped");
   endtask

   // random timestamp not held yet, next locale
   function automatic tq_elem_s new_task(input int t);
      tq_elem_s    e;
      logic [31:0] r;
      r = lcg_next();
      while (ts_in_use(ts_t'(r[23:16]))) begin
         r = lcg_next();
      end
      e.ttype    = ttype_t'(t);
      e.locale   = locale_seq;
      e.ts       = r[23:16];
      locale_seq = locale_seq + 16'd1;
      return e;
   endfunction

   // called on a falling edge, returns on a falling edge
   task automatic write_elem(input tq_elem_s e);
      int n;
      n        = 0;
      s_wvalid = 1'b1;
      s_wdata  = e;
      #1;
      while (!s_wready) begin
         n++;
         if (n > WAIT_MAX) begin
            stop_run("timeout: the write port never became ready");
         end
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      s_wvalid = 1'b0;
      model_write(e);
   endtask

   // heap settled and a task waiting on port t
   task automatic wait_settled(input int t);
      int n;
      n = 0;
      #1;
      while (!(m_rvalid[t] && s_wready)) begin
         n++;
         if (n > WAIT_MAX) begin
            stop_run($sformatf("timeout: no task showed up on port %0d", t));
         end
         @(negedge clk);
         #1;
      end
      @(negedge clk);
   endtask

   // one read with a one-cycle ready pulse
   task automatic read_one(input int t, input string test);
      tq_elem_s e;
      wait_settled(t);
      if (!model_expect(t, e)) begin
         stop_run($sformatf("%s: port %0d holds a task the model lacks", test, t));
      end
      check(test, 32'({e.ts, e.locale}), 32'(m_rdata[t]));
      m_rready[t] = 1'b1;
      @(negedge clk);
      m_rready[t] = 1'b0;
      // heap head refills the slot on the same edge
      model_settle();
   endtask

   // every port ready until the model is empty
   task automatic collect_all(input string test);
      tq_elem_s e;
      int       n;
      n        = 0;
      m_rready = '1;
      while (model_count() > 0) begin
         for (int t = 0; t < N; t++) begin
            if (m_rvalid[t]) begin
               if (!model_expect(t, e)) begin
                  stop_run($sformatf("%s: port %0d gave an unexpected task", test, t));
               end
               check(test, 32'({e.ts, e.locale}), 32'(m_rdata[t]));
            end
         end
         @(negedge clk);
         n++;
         if (n > WAIT_MAX) begin
            stop_run($sformatf("timeout: %s left tasks undelivered", test));
         end
      end
      m_rready = '0;
      // no extra deliveries once everything is out
      repeat (4) begin
         @(negedge clk);
         check(test, 32'(0), 32'(m_rvalid));
      end
   endtask

   task automatic test_sorted_drain();
      m_rready = '0;
      repeat (15) begin
         write_elem(new_task(0));
      end
      collect_all("sorted_drain");
   endtask

   task automatic test_full_backpressure();
      int accepted;
      int idle;
      accepted = 0;
      idle     = 0;
      m_rready = '0;
      s_wdata  = new_task(0);
      s_wvalid = 1'b1;
      // ends once ready stays low for 20 cycles
      while (idle < 20 && accepted < 40) begin
         #1;
         if (s_wready) begin
            accepted++;
            idle = 0;
            model_write(s_wdata);
            @(negedge clk);
            s_wdata = new_task(0);
         end else begin
            idle++;
            @(negedge clk);
         end
      end
      s_wvalid = 1'b0;
      // 15 in the heap and one in the slot
      check("full_backpressure", 32'(16), 32'(accepted));
      collect_all("full_backpressure");
   endtask

   task automatic test_type_routing();
      logic [31:0] r;
      m_rready = '0;
      repeat (15) begin
         r = lcg_next();
         write_elem(new_task(int'(r % N)));
      end
      collect_all("type_routing");
   endtask

   task automatic test_read_stall();
      task_t held;
      m_rready = '0;
      write_elem(new_task(2));
      wait_settled(2);
      held = m_rdata[2];
      repeat (6) begin
         @(negedge clk);
         check("read_stall", 32'(1), 32'(m_rvalid[2]));
         check("read_stall", 32'(held), 32'(m_rdata[2]));
      end
      read_one(2, "read_stall");
      repeat (4) begin
         @(negedge clk);
         check("read_stall", 32'(0), 32'(m_rvalid[2]));
      end
   endtask

   task automatic test_interleaved();
      logic [31:0] r;
      m_rready = '0;
      for (int i = 0; i < 40; i++) begin
         r = lcg_next();
         if (model_count() == 0 || (r[20] && model_count() < 12)) begin
            write_elem(new_task(0));
         end else begin
            read_one(0, "interleaved");
         end
      end
      collect_all("interleaved");
   endtask

   task automatic test_reset();
      logic [31:0] r;
      m_rready = '0;
      repeat (6) begin
         r = lcg_next();
         write_elem(new_task(int'(r % N)));
      end
      // one more write in flight as reset hits
      s_wdata  = new_task(1);
      s_wvalid = 1'b1;
      @(negedge clk);
      rst      = 1'b1;
      s_wvalid = 1'b0;
      repeat (2) begin
         @(negedge clk);
      end
      rst = 1'b0;
      model_clear();
      #1;
      check("reset", 32'(0), 32'(m_rvalid));
      check("reset", 32'(1), 32'(s_wready));
      @(negedge clk);
      test_sorted_drain();
   endtask

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      s_wvalid   = 1'b0;
      s_wdata    = '0;
      m_rready   = '0;
      errors     = 0;
      locale_seq = 16'h0100;
      lcg_state  = 32'ha62c_20de;
      model_clear();
      repeat (2) begin
         @(negedge clk);
      end
      rst = 1'b0;
      test_sorted_drain();
      test_full_backpressure();
      test_type_routing();
      test_read_stall();
      test_interleaved();
      test_reset();
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* run.sh */
#!/bin/sh
# build the task unit testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module tb_task_unit

# the log decides the result, so a fatal stop still reaches the search below
./obj_dir/Vtb_task_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
   exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
   echo "simulation ended without a result line"
   exit 1
fi
exit 0

/* tb.f */
+incdir+design
+incdir+dv
design/task_pkg.sv
design/tq_pkg.sv
design/task_heap.sv
design/task_dispatch.sv
design/task_unit.sv
dv/tb_task_unit.sv
